/* hw/gamePkg.sv */
////////////////////
// shared pixel path definitions
// color type, coordinate width, pipeline depth
// scan phase enum and digit font
////////////////////

`default_nettype none

package gamePkg;

	// RGB332 color, red in the top bits
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb_t;

	// screen coordinate width
	parameter int coordW = 11;

	// register stages from scan position to output color
	parameter int pipeDepth = 2;

	// phases of a scan line or a frame
	typedef enum logic [1:0] {
		active,
		frontPorch,
		sync,
		backPorch
	} scanPhase_t;

	// ten glyphs of 8 rows by 4 columns
	// index 0 of a row is the leftmost pixel (the MSB of each nibble)
	parameter logic [0:9][0:7][0:3] digitFont = {
		32'h6999_9960,
		32'h2622_2270,
		32'h6912_48F0,
		32'hE116_11E0,
		32'h999F_1110,
		32'hF8E1_1960,
		32'h68E9_9960,
		32'hF124_4440,
		32'h6996_9960,
		32'h6997_1160
	};

endpackage

`default_nettype wire

/* hw/pixelIf.sv */
////////////////////
// scan position interface
// timing generator to drawers
////////////////////

`default_nettype none

interface pixelIf;
	logic [gamePkg::coordW-1:0] pixelX;
	logic [gamePkg::coordW-1:0] pixelY;
	logic visible;
	logic frameStart;
	// visible one cycle late, lines up with the drawer outputs
	logic visibleD;

	modport source (
		output pixelX, pixelY, visible, frameStart, visibleD
	);

	modport sink (
		input pixelX, pixelY, visible, frameStart, visibleD
	);
endinterface

`default_nettype wire

/* hw/vgaTiming.sv */
////////////////////
// raster timing generator
// line and frame counters with phase state
// sync outputs delayed to match the color pipeline
////////////////////

`default_nettype none

module vgaTiming #(
	parameter int hActive = 640,
	parameter int hFront = 16,
	parameter int hSync = 96,
	parameter int hBack = 48,
	parameter int vActive = 480,
	parameter int vFront = 10,
	parameter int vSync = 2,
	parameter int vBack = 33
) (
	input logic clk,
	input logic resetN,
	pixelIf.source pix,
	output logic hSyncN,
	output logic vSyncN
);

	localparam int hTotal = hActive + hFront + hSync + hBack;
	localparam int vTotal = vActive + vFront + vSync + vBack;
	// after reset the scan starts at the first blank line
	localparam logic [gamePkg::coordW-1:0] vStartCount = vActive[gamePkg::coordW-1:0];

	logic [gamePkg::coordW-1:0] hCount;
	logic [gamePkg::coordW-1:0] vCount;
	gamePkg::scanPhase_t hPhase;
	gamePkg::scanPhase_t vPhase;
	logic lineEnd;
	logic frameEnd;
	logic visible;
	logic visibleDReg;
	logic [gamePkg::pipeDepth-1:0] hSyncPipe;
	logic [gamePkg::pipeDepth-1:0] vSyncPipe;

	assign lineEnd = int'(hCount) == hTotal - 1;
	assign frameEnd = lineEnd && (int'(vCount) == vTotal - 1);

	// horizontal counter, phase moves on the last pixel of a region
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hCount <= '0;
			hPhase <= gamePkg::active;
		end else begin
			if (lineEnd)
				hCount <= '0;
			else
				hCount <= hCount + 1'b1;
			if (int'(hCount) == hActive - 1)
				hPhase <= gamePkg::frontPorch;
			else if (int'(hCount) == hActive + hFront - 1)
				hPhase <= gamePkg::sync;
			else if (int'(hCount) == hActive + hFront + hSync - 1)
				hPhase <= gamePkg::backPorch;
			else if (lineEnd)
				hPhase <= gamePkg::active;
		end
	end

	// vertical counter steps once per line
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			vCount <= vStartCount;
			vPhase <= gamePkg::frontPorch;
		end else if (lineEnd) begin
			if (frameEnd)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
			if (int'(vCount) == vActive - 1)
				vPhase <= gamePkg::frontPorch;
			else if (int'(vCount) == vActive + vFront - 1)
				vPhase <= gamePkg::sync;
			else if (int'(vCount) == vActive + vFront + vSync - 1)
				vPhase <= gamePkg::backPorch;
			else if (frameEnd)
				vPhase <= gamePkg::active;
		end
	end

	assign visible = (hPhase == gamePkg::active) && (vPhase == gamePkg::active);

	// sync delay and late visible copy
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hSyncPipe <= '1;
			vSyncPipe <= '1;
			visibleDReg <= 1'b0;
		end else begin
			hSyncPipe <= {hSyncPipe[gamePkg::pipeDepth-2:0], hPhase != gamePkg::sync};
			vSyncPipe <= {vSyncPipe[gamePkg::pipeDepth-2:0], vPhase != gamePkg::sync};
			visibleDReg <= visible;
		end
	end

	assign hSyncN = hSyncPipe[gamePkg::pipeDepth-1];
	assign vSyncN = vSyncPipe[gamePkg::pipeDepth-1];

	assign pix.pixelX = hCount;
	assign pix.pixelY = vCount;
	assign pix.visible = visible;
	assign pix.frameStart = (hCount == '0) && (vCount == '0);
	assign pix.visibleD = visibleDReg;

endmodule

`default_nettype wire

/* hw/rectangleObject.sv */
////////////////////
// solid rectangle drawer
////////////////////

`default_nettype none

module rectangleObject #(
	parameter int rectWidth = 40,
	parameter int rectHeight = 30,
	parameter gamePkg::rgb_t rectColor = 8'hE0
) (
	input logic clk,
	input logic resetN,
	pixelIf.sink pix,
	input logic [gamePkg::coordW-1:0] rectX,
	input logic [gamePkg::coordW-1:0] rectY,
	output logic drawingRequest,
	output gamePkg::rgb_t rgb
);

	logic [gamePkg::coordW-1:0] rectXLatched;
	logic [gamePkg::coordW-1:0] rectYLatched;
	logic [gamePkg::coordW-1:0] posX;
	logic [gamePkg::coordW-1:0] posY;
	logic insideX;
	logic insideY;

	// position is taken once per frame
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			rectXLatched <= '0;
			rectYLatched <= '0;
		end else if (pix.frameStart) begin
			rectXLatched <= rectX;
			rectYLatched <= rectY;
		end
	end

	// the first pixel of a frame already sees the new position
	assign posX = pix.frameStart ? rectX : rectXLatched;
	assign posY = pix.frameStart ? rectY : rectYLatched;

	assign insideX = (pix.pixelX >= posX) && (int'(pix.pixelX) < int'(posX) + rectWidth);
	assign insideY = (pix.pixelY >= posY) && (int'(pix.pixelY) < int'(posY) + rectHeight);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawingRequest <= 1'b0;
			rgb <= '0;
		end else begin
			drawingRequest <= pix.visible && insideX && insideY;
			rgb <= rectColor;
		end
	end

endmodule

`default_nettype wire

/* hw/digitObject.sv */
////////////////////
// single decimal digit drawer
// font glyph scaled by two in both directions
////////////////////

`default_nettype none

module digitObject #(
	parameter int digitX = 600,
	parameter int digitY = 20,
	parameter gamePkg::rgb_t digitColor = 8'hFF
) (
	input logic clk,
	input logic resetN,
	pixelIf.sink pix,
	input logic [3:0] digitValue,
	output logic drawingRequest,
	output gamePkg::rgb_t rgb
);

	// box covered by one glyph on screen
	localparam int boxWidth = 8;
	localparam int boxHeight = 16;

	logic [3:0] digitLatched;
	logic [3:0] digitCur;
	logic digitValid;
	int dx;
	int dy;
	logic inBox;
	logic [2:0] rowIdx;
	logic [1:0] colIdx;
	logic [0:7][0:3] glyph;
	logic fontBit;

	// digit is taken once per frame
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			digitLatched <= '0;
		else if (pix.frameStart)
			digitLatched <= digitValue;
	end

	assign digitCur = pix.frameStart ? digitValue : digitLatched;
	assign digitValid = digitCur <= 4'd9;

	// offset inside the box, each font bit is 2x2 pixels
	always_comb begin
		dx = int'(pix.pixelX) - digitX;
		dy = int'(pix.pixelY) - digitY;
		inBox = (dx >= 0) && (dx < boxWidth) && (dy >= 0) && (dy < boxHeight);
		colIdx = dx[2:1];
		rowIdx = dy[3:1];
	end

	// values above 9 have no glyph
	always_comb begin
		if (digitValid)
			glyph = gamePkg::digitFont[digitCur];
		else
			glyph = '0;
		fontBit = glyph[rowIdx][colIdx];
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawingRequest <= 1'b0;
			rgb <= '0;
		end else begin
			drawingRequest <= pix.visible && inBox && fontBit;
			rgb <= digitColor;
		end
	end

endmodule

`default_nettype wire

/* hw/objectsMux.sv */
////////////////////
// object priority mux
// RGB332 to 24-bit expansion
////////////////////

`default_nettype none

module objectsMux (
	input logic clk,
	input logic resetN,
	input logic visible,
	input logic digitRequest,
	input gamePkg::rgb_t digitRgb,
	input logic rectRequest,
	input gamePkg::rgb_t rectRgb,
	input gamePkg::rgb_t backgroundRgb,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	gamePkg::rgb_t colorReg;

	// digit wins over rectangle, rectangle over background
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			colorReg <= '0;
		else if (!visible)
			colorReg <= '0;
		else if (digitRequest)
			colorReg <= digitRgb;
		else if (rectRequest)
			colorReg <= rectRgb;
		else
			colorReg <= backgroundRgb;
	end

	// repeat channel bits msb first to fill the byte
	assign red = {colorReg.r, colorReg.r, colorReg.r[2:1]};
	assign green = {colorReg.g, colorReg.g, colorReg.g[2:1]};
	assign blue = {4{colorReg.b}};

endmodule

`default_nettype wire

/* hw/pixelPipeTop.sv */
////////////////////
// pixel path top level
// timing, rectangle, digit and mux
////////////////////

`default_nettype none

module pixelPipeTop #(
	parameter int hActive = 640,
	parameter int hFront = 16,
	parameter int hSync = 96,
	parameter int hBack = 48,
	parameter int vActive = 480,
	parameter int vFront = 10,
	parameter int vSync = 2,
	parameter int vBack = 33,
	parameter int rectWidth = 40,
	parameter int rectHeight = 30,
	parameter gamePkg::rgb_t rectColor = 8'hE0,
	parameter int digitX = 600,
	parameter int digitY = 20,
	parameter gamePkg::rgb_t digitColor = 8'hFF
) (
	input logic clk,
	input logic resetN,
	input logic [gamePkg::coordW-1:0] rectX,
	input logic [gamePkg::coordW-1:0] rectY,
	input logic [3:0] digitValue,
	input logic [7:0] backgroundRgb,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	output logic hSyncN,
	output logic vSyncN
);

	logic rectRequest;
	gamePkg::rgb_t rectRgb;
	logic digitRequest;
	gamePkg::rgb_t digitRgb;

	pixelIf pix ();

	vgaTiming #(
		.hActive(hActive),
		.hFront(hFront),
		.hSync(hSync),
		.hBack(hBack),
		.vActive(vActive),
		.vFront(vFront),
		.vSync(vSync),
		.vBack(vBack)
	) timing0 (
		.clk(clk),
		.resetN(resetN),
		.pix(pix.source),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN)
	);

	rectangleObject #(
		.rectWidth(rectWidth),
		.rectHeight(rectHeight),
		.rectColor(rectColor)
	) rect0 (
		.clk(clk),
		.resetN(resetN),
		.pix(pix.sink),
		.rectX(rectX),
		.rectY(rectY),
		.drawingRequest(rectRequest),
		.rgb(rectRgb)
	);

	digitObject #(
		.digitX(digitX),
		.digitY(digitY),
		.digitColor(digitColor)
	) digit0 (
		.clk(clk),
		.resetN(resetN),
		.pix(pix.sink),
		.digitValue(digitValue),
		.drawingRequest(digitRequest),
		.rgb(digitRgb)
	);

	// mux sees visible one cycle late, in step with the drawers
	objectsMux mux0 (
		.clk(clk),
		.resetN(resetN),
		.visible(pix.visibleD),
		.digitRequest(digitRequest),
		.digitRgb(digitRgb),
		.rectRequest(rectRequest),
		.rectRgb(rectRgb),
		.backgroundRgb(backgroundRgb),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

`default_nettype wire

/* verification/pixelPipe_props.sv */
////////////////////
// pixel path property checker
// scan position rebuilt from the syncs
// sync and color assertions, bind to the top level
////////////////////

`default_nettype none

module pixelPipe_props #(
	parameter int hActive = 32,
	parameter int hFront = 4,
	parameter int hSync = 6,
	parameter int hBack = 6,
	parameter int vActive = 24,
	parameter int vFront = 2,
	parameter int vSync = 2,
	parameter int vBack = 3,
	parameter int rectWidth = 10,
	parameter int rectHeight = 8,
	parameter gamePkg::rgb_t rectColor = 8'hE0,
	parameter int digitX = 20,
	parameter int digitY = 4,
	parameter gamePkg::rgb_t digitColor = 8'hFF
) (
	input logic clk,
	input logic resetN,
	input logic [gamePkg::coordW-1:0] rectX,
	input logic [gamePkg::coordW-1:0] rectY,
	input logic [3:0] digitValue,
	input logic [7:0] backgroundRgb,
	input logic [7:0] red,
	input logic [7:0] green,
	input logic [7:0] blue,
	input logic hSyncN,
	input logic vSyncN
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int hTotal = hActive + hFront + hSync + hBack;
	localparam int vTotal = vActive + vFront + vSync + vBack;
	// output position where each sync pulse begins
	localparam int hSyncStart = hActive + hFront;
	localparam int vSyncStart = vActive + vFront;
	// rectX, rectY and digitValue side by side
	localparam int inW = 2 * gamePkg::coordW + 4;

	logic started = 1'b0;
	logic quietFail = 1'b0;
	logic hSyncFail = 1'b0;
	logic vSyncFail = 1'b0;
	logic colorFail = 1'b0;
	logic checkFailed;
	logic hSeen;
	logic vSeen;
	logic hSyncPrev;
	logic vSyncPrev;
	logic hFall;
	logic vFall;
	logic frameFirst;
	int xLast;
	int yLast;
	int xCur;
	int yCur;
	logic [inW-1:0] inputsD1;
	logic [inW-1:0] inputsD2;
	logic [inW-1:0] inputsFrame;
	logic [inW-1:0] frameIn;
	logic [7:0] bgPrev;
	int rx;
	int ry;
	int dx;
	int dy;
	logic [3:0] dig;
	logic [2:0] rowIdx;
	logic [1:0] colIdx;
	logic fontHit;
	gamePkg::rgb_t expColor;
	logic [23:0] expRgb;
	logic expHSyncN;
	logic expVSyncN;

	// repeat the channel bits msb first until the byte is full
	function automatic logic [7:0] expandChannel(input logic [2:0] bits, input int width);
		logic [7:0] result;
		for (int i = 0; i < 8; i++)
			result[7 - i] = bits[width - 1 - (i % width)];
		return result;
	endfunction

	// position of the pixel now at the outputs
	always_comb begin
		hFall = hSyncPrev && !hSyncN;
		vFall = vSyncPrev && !vSyncN;
		if (hSeen)
			xCur = (xLast == hTotal - 1) ? 0 : xLast + 1;
		else if (hFall)
			xCur = hSyncStart;
		else
			xCur = 0;
		if (vSeen)
			yCur = (xCur != 0) ? yLast : ((yLast == vTotal - 1) ? 0 : yLast + 1);
		else if (vFall)
			yCur = vSyncStart;
		else
			yCur = 0;
		frameFirst = vSeen && (xCur == 0) && (yCur == 0);
	end

	// reference color from the priority rules
	always_comb begin
		frameIn = frameFirst ? inputsD2 : inputsFrame;
		rx = int'(frameIn[4 + gamePkg::coordW +: gamePkg::coordW]);
		ry = int'(frameIn[4 +: gamePkg::coordW]);
		dig = frameIn[3:0];
		dx = xCur - digitX;
		dy = yCur - digitY;
		rowIdx = 3'(dy >> 1);
		colIdx = 2'(dx >> 1);
		fontHit = (dig <= 4'd9) && (dx >= 0) && (dx < 8) && (dy >= 0) && (dy < 16);
		if (fontHit)
			fontHit = gamePkg::digitFont[dig][rowIdx][colIdx];
		if (fontHit)
			expColor = digitColor;
		else if (xCur >= rx && xCur < rx + rectWidth && yCur >= ry && yCur < ry + rectHeight)
			expColor = rectColor;
		else
			expColor = bgPrev;
		if (!vSeen || xCur >= hActive || yCur >= vActive)
			expRgb = '0;
		else
			expRgb = {expandChannel(expColor.r, 3), expandChannel(expColor.g, 3),
				expandChannel({1'b0, expColor.b}, 2)};
	end

	assign expHSyncN = !(xCur >= hSyncStart && xCur < hSyncStart + hSync);
	assign expVSyncN = !(yCur >= vSyncStart && yCur < vSyncStart + vSync);
	assign checkFailed = quietFail || hSyncFail || vSyncFail || colorFail;

	// state is unknown before the first clock edge
	always_ff @(posedge clk)
		started <= 1'b1;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hSeen <= 1'b0;
			vSeen <= 1'b0;
			hSyncPrev <= 1'b1;
			vSyncPrev <= 1'b1;
			xLast <= 0;
			yLast <= 0;
			inputsD1 <= '0;
			inputsD2 <= '0;
			inputsFrame <= '0;
			bgPrev <= '0;
		end else begin
			hSeen <= hSeen || hFall;
			vSeen <= vSeen || (hSeen && vFall);
			hSyncPrev <= hSyncN;
			vSyncPrev <= vSyncN;
			xLast <= xCur;
			yLast <= yCur;
			// drawers take their inputs two edges before the color shows
			inputsD1 <= {rectX, rectY, digitValue};
			inputsD2 <= inputsD1;
			bgPrev <= backgroundRgb;
			if (frameFirst)
				inputsFrame <= inputsD2;
		end
	end

	// syncs stay high in reset, afterwards the first hsync fall starts the line
	quietStart: assert property (@(posedge clk)
		started && !hSeen |-> vSyncN && (hSyncN || (resetN && hFall)) &&
			({red, green, blue} == 24'h0))
		else begin
			quietFail = 1'b1;
			$error("error at %0t: {hSyncN, vSyncN} is %b and {red, green, blue} is %h, %s",
				$time, $sampled({hSyncN, vSyncN}), $sampled({red, green, blue}),
				"expected 11 and 000000 before the first line");
		end

	hSyncShape: assert property (@(posedge clk) hSeen |-> hSyncN == expHSyncN)
		else begin
			hSyncFail = 1'b1;
			$error("error at %0t: hSyncN is %b, expected %b",
				$time, $sampled(hSyncN), $sampled(expHSyncN));
		end

	vSyncShape: assert property (@(posedge clk) vSeen |-> vSyncN == expVSyncN)
		else begin
			vSyncFail = 1'b1;
			$error("error at %0t: vSyncN is %b, expected %b",
				$time, $sampled(vSyncN), $sampled(expVSyncN));
		end

	colorValue: assert property (@(posedge clk) hSeen |-> {red, green, blue} == expRgb)
		else begin
			colorFail = 1'b1;
			$error("error at %0t: {red, green, blue} is %h, expected %h",
				$time, $sampled({red, green, blue}), $sampled(expRgb));
		end

endmodule

bind pixelPipeTop pixelPipe_props #(
	.hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
	.vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack),
	.rectWidth(rectWidth), .rectHeight(rectHeight), .rectColor(rectColor),
	.digitX(digitX), .digitY(digitY), .digitColor(digitColor)
) props0 (.*);

`default_nettype wire

/* verification/pixelPipeTb.sv */
////////////////////
// pixel path testbench
// clock, reset, random stimulus per frame
// watchdog and final verdict
////////////////////

`default_nettype none

module pixelPipeTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int hActive = 32;
	localparam int hFront = 4;
	localparam int hSync = 6;
	localparam int hBack = 6;
	localparam int vActive = 24;
	localparam int vFront = 2;
	localparam int vSync = 2;
	localparam int vBack = 3;
	localparam int lineCycles = hActive + hFront + hSync + hBack;
	localparam int frameCycles = lineCycles * (vActive + vFront + vSync + vBack);
	localparam int frameCount = 12;
	localparam int clkPeriod = 40;
	localparam logic [15:0] lfsrSeed = 16'd60776;

	logic clk;
	logic resetN;
	logic [gamePkg::coordW-1:0] rectX;
	logic [gamePkg::coordW-1:0] rectY;
	logic [3:0] digitValue;
	logic [7:0] backgroundRgb;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	logic hSyncN;
	logic vSyncN;
	logic [15:0] lfsrState;

	pixelPipeTop #(
		.hActive(hActive),
		.hFront(hFront),
		.hSync(hSync),
		.hBack(hBack),
		.vActive(vActive),
		.vFront(vFront),
		.vSync(vSync),
		.vBack(vBack),
		.rectWidth(10),
		.rectHeight(8),
		.rectColor(8'h1C),
		.digitX(20),
		.digitY(4),
		.digitColor(8'hFF)
	) dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// galois lfsr, polynomial x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] stepLfsr(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic takeBits(input int width, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsrState = stepLfsr(lfsrState);
			value = {value[14:0], lfsrState[0]};
		end
	endtask

	initial begin
		logic [15:0] bits;
		int offset;
		lfsrState = lfsrSeed;
		resetN = 1'b0;
		rectX = '0;
		rectY = '0;
		digitValue = '0;
		backgroundRgb = '0;
		repeat (4) @(negedge clk);
		resetN = 1'b1;
		for (int frame = 0; frame < frameCount; frame++) begin
			// change point lands anywhere in the frame
			takeBits(10, bits);
			offset = int'(bits);
			repeat (offset) @(negedge clk);
			takeBits(6, bits);
			rectX = bits[gamePkg::coordW-1:0];
			takeBits(5, bits);
			rectY = bits[gamePkg::coordW-1:0];
			takeBits(4, bits);
			digitValue = bits[3:0];
			takeBits(8, bits);
			backgroundRgb = bits[7:0];
			repeat (frameCycles - offset) @(negedge clk);
		end
		@(negedge clk);
		if (dut0.props0.checkFailed) begin
			$display("** FAIL **");
			$fatal(1, "a property check failed");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

	// first assertion failure ends the run
	initial begin
		wait (dut0.props0.checkFailed);
		$display("** FAIL **");
		$fatal(1, "a property check failed");
	end

	// all frames plus two frames of margin
	initial begin
		#(clkPeriod * (frameCount + 2) * frameCycles);
		$display("** FAIL **");
		$fatal(1, "timeout, the stimulus did not finish in time");
	end

endmodule

`default_nettype wire

/* list.f */
hw/gamePkg.sv
hw/pixelIf.sv
hw/vgaTiming.sv
hw/rectangleObject.sv
hw/digitObject.sv
hw/objectsMux.sv
hw/pixelPipeTop.sv
verification/pixelPipe_props.sv
verification/pixelPipeTb.sv

/* run.sh */
#!/bin/sh
# build and run the pixel path testbench with Verilator

verilator --binary --timing --assert -f list.f --top-module pixelPipeTb \
	--Mdir obj_dir -o pixelPipeSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running after an assertion so the testbench reports the failure
output=$(./obj_dir/pixelPipeSim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1
